// File: bench/bridge_golden.txt
// ph sa cmd wd wm vf dc rv rd, then expected ea ecmd ewd ewm evf sv srd
// seq columns sa..vf apply on ph 1 lines only and are zero on ph 0 lines
1 3578123 023730 00000000 000 0 0 0 0000 0000 00f0 0000 000 0 0 00000000
0 0000000 000000 00000000 000 0 0 0 0000 0000 00f0 0000 000 0 0 00000000
1 0000010 52f740 11112222 ff9 6 0 1 d0a0 0000 00f0 0000 000 6 0 00000000
0 0000000 000000 00000000 000 0 0 1 d1a1 0000 00f0 0000 000 0 0 00000000
1 0aaaf0f 00f770 33334444 fb3 9 0 1 d2a2 0123 2130 0000 000 9 0 00000000
0 0000000 000000 00000000 000 0 0 1 d3a3 1abc 0170 0000 000 0 0 00000000
1 0000020 013751 00000000 000 3 1 0 0000 0010 2340 2222 331 3 1 d1a1d0a0
0 0000000 000000 00000000 000 0 0 0 0000 0000 5370 1111 332 0 1 d1a1d0a0
1 0000000 003ff0 00000000 000 0 1 0 0000 0f0f 0370 4444 333 0 1 d3a3d2a2
0 0000000 000000 00000000 000 0 0 0 0000 0555 0370 3333 320 0 1 d3a3d2a2
1 0000000 003ff0 00000000 000 0 2 0 0000 0020 1151 0000 000 0 0 00000000
0 0000000 000000 00000000 000 0 2 0 0000 0000 0171 0000 000 0 0 00000000
1 0000000 003ff0 00000000 000 0 2 0 0000 0000 01f0 0000 000 0 0 00000000
0 0000000 000000 00000000 000 0 2 1 e0b0 0000 01f0 0000 000 0 0 00000000
1 0000000 003ff0 00000000 000 0 0 1 e1b1 0000 01f0 0000 000 0 0 00000000
0 0000000 000000 00000000 000 0 0 1 e2b2 0000 01f0 0000 000 0 0 00000000
1 0000000 003ff0 00000000 000 0 0 1 e3b3 0000 01f0 0000 000 0 1 e1b1e0b0
0 0000000 000000 00000000 000 0 0 0 0000 0000 01f0 0000 000 0 1 e1b1e0b0
1 0000000 003ff0 00000000 000 0 0 0 0000 0000 01f0 0000 000 0 1 e3b3e2b2
0 0000000 000000 00000000 000 0 0 0 0000 0000 01f0 0000 000 0 1 e3b3e2b2
1 0000000 003ff0 00000000 000 0 0 0 0000 0000 01f0 0000 000 0 0 00000000
0 0000000 000000 00000000 000 0 0 0 0000 0000 01f0 0000 000 0 0 00000000

// File: tb.f
+incdir+hdl
hdl/rate_bridge_pkg.sv
hdl/rate_bridge_if.sv
hdl/cmd_slot_shifter.sv
hdl/ddr_phase_serializer.sv
hdl/read_phase_aligner.sv
hdl/seq_rate_bridge.sv
bench/bridge_clock_gen.sv
bench/seq_rate_bridge_props.sv
bench/tb_seq_rate_bridge.sv

// File: bench/tb_seq_rate_bridge.sv
/*
  Golden-file testbench for seq_rate_bridge with SHIFT_ADDR_CMD = 0.
  Each golden line is one half cycle, ph 1 after a rising edge, ph 0 after a
  falling edge. Field packing assumes the default widths: cmd is
  {bank_h, bank_l, odt_h odt_l cke_h cke_l, cs ras cas we high, same low, rdata_en},
  one field per hex digit, and ecmd is {bank, odt cke, cs ras cas we, rdata_en}.
  wm is {dqs_en, wdata_valid, dm} and vf is {fr, hr}. dc bit 0 fills seq_wdata
  from $random, dc bit 1 skips the mux_wdata check, srd is checked only when sv is 1.
*/
`timescale 1ns/1ps

module tb_seq_rate_bridge;
	import rate_bridge_pkg::*;

	localparam int COLS      = 16;
	localparam int MAX_LINES = 64;

	localparam int C_PH   = 0;
	localparam int C_SA   = 1;
	localparam int C_CMD  = 2;
	localparam int C_WD   = 3;
	localparam int C_WM   = 4;
	localparam int C_VF   = 5;
	localparam int C_DC   = 6;
	localparam int C_RV   = 7;
	localparam int C_RD   = 8;
	localparam int C_EA   = 9;
	localparam int C_ECMD = 10;
	localparam int C_EWD  = 11;
	localparam int C_EWM  = 12;
	localparam int C_EVF  = 13;
	localparam int C_SV   = 14;
	localparam int C_SRD  = 15;

	logic       seq_clk;
	logic       reset_n_seq_clk;
	seq_addr_t  seq_address;
	seq_bank_t  seq_bank;
	seq_cs_t    seq_cs_n;
	seq_cke_t   seq_cke;
	seq_odt_t   seq_odt;
	seq_ctl_t   seq_ras_n;
	seq_ctl_t   seq_cas_n;
	seq_ctl_t   seq_we_n;
	seq_dqs_t   seq_dqs_en;
	seq_data_t  seq_wdata;
	seq_dqs_t   seq_wdata_valid;
	seq_dm_t    seq_dm;
	logic       seq_rdata_en;
	seq_data_t  seq_rdata;
	logic       seq_rdata_valid;
	vfifo_inc_t seq_read_increment_vfifo_fr;
	vfifo_inc_t seq_read_increment_vfifo_hr;
	afi_addr_t  mux_address;
	afi_bank_t  mux_bank;
	afi_cs_t    mux_cs_n;
	afi_cke_t   mux_cke;
	afi_odt_t   mux_odt;
	afi_ctl_t   mux_ras_n;
	afi_ctl_t   mux_cas_n;
	afi_ctl_t   mux_we_n;
	afi_dqs_t   mux_dqs_en;
	afi_data_t  mux_wdata;
	afi_dqs_t   mux_wdata_valid;
	afi_dm_t    mux_dm;
	logic       mux_rdata_en;
	afi_data_t  mux_rdata;
	logic       mux_rdata_valid;
	vfifo_inc_t phy_read_increment_vfifo_fr;
	vfifo_inc_t phy_read_increment_vfifo_hr;

	logic [31:0] golden [COLS*MAX_LINES];
	int          num_lines;
	int          errors;
	int          checks;
	int          seed;
	logic        golden_ready;

	bridge_clock_gen i_clock_gen (
		.seq_clk         (seq_clk),
		.reset_n_seq_clk (reset_n_seq_clk)
	);

	seq_rate_bridge #(
		.SHIFT_ADDR_CMD (0)
	) i_dut (
		.*
	);

	function automatic logic [31:0] field(input int line, input int col);
		return golden[line*COLS + col];
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
	                           input logic [31:0] actual);
		checks++;
		assert (actual === expected)
		else
		begin
			$display("ERROR %s expected %0h got %0h at %0t", name, expected, actual, $time);
			errors++;
		end
	endtask

	task automatic drive_seq_inputs(input int line);
		logic [31:0] cmd;
		logic [31:0] wm;
		logic [31:0] vf;
		cmd = field(line, C_CMD);
		wm  = field(line, C_WM);
		vf  = field(line, C_VF);
		seq_address  = field(line, C_SA);
		seq_bank     = {cmd[22:20], cmd[18:16]};
		seq_odt      = cmd[15:14];
		seq_cke      = cmd[13:12];
		seq_cs_n     = {cmd[11], cmd[7]};
		seq_ras_n    = {cmd[10], cmd[6]};
		seq_cas_n    = {cmd[9], cmd[5]};
		seq_we_n     = {cmd[8], cmd[4]};
		seq_rdata_en = cmd[0];
		if (field(line, C_DC) & 32'h1)
			seq_wdata = $random(seed);
		else
			seq_wdata = field(line, C_WD);
		seq_dqs_en      = wm[11:8];
		seq_wdata_valid = wm[7:4];
		seq_dm          = wm[3:0];
		seq_read_increment_vfifo_fr = vf[3:2];
		seq_read_increment_vfifo_hr = vf[1:0];
	endtask

	task automatic check_outputs(input int line);
		logic [31:0] ecmd;
		logic [31:0] ewm;
		logic [31:0] evf;
		logic [31:0] sv;
		ecmd = field(line, C_ECMD);
		ewm  = field(line, C_EWM);
		evf  = field(line, C_EVF);
		sv   = field(line, C_SV);
		check_value("mux_address", field(line, C_EA), mux_address);
		check_value("mux_bank", ecmd[14:12], mux_bank);
		check_value("mux_odt", ecmd[9], mux_odt);
		check_value("mux_cke", ecmd[8], mux_cke);
		check_value("mux_cs_n", ecmd[7], mux_cs_n);
		check_value("mux_ras_n", ecmd[6], mux_ras_n);
		check_value("mux_cas_n", ecmd[5], mux_cas_n);
		check_value("mux_we_n", ecmd[4], mux_we_n);
		check_value("mux_rdata_en", ecmd[0], mux_rdata_en);
		if (!(field(line, C_DC) & 32'h2))
			check_value("mux_wdata", field(line, C_EWD), mux_wdata);
		check_value("mux_dqs_en", ewm[9:8], mux_dqs_en);
		check_value("mux_wdata_valid", ewm[5:4], mux_wdata_valid);
		check_value("mux_dm", ewm[1:0], mux_dm);
		check_value("phy_read_increment_vfifo_fr", evf[3:2], phy_read_increment_vfifo_fr);
		check_value("phy_read_increment_vfifo_hr", evf[1:0], phy_read_increment_vfifo_hr);
		check_value("seq_rdata_valid", sv[0], seq_rdata_valid);
		if (sv[0])
			check_value("seq_rdata", field(line, C_SRD), seq_rdata);
	endtask

	// half-rate inputs change only after a rising edge, read beats after both edges
	task automatic run_line(input int line);
		logic [31:0] ph;
		ph = field(line, C_PH);
		if (ph == 32'h1)
			@(posedge seq_clk);
		else
			@(negedge seq_clk);
		#1;
		if (ph == 32'h1)
			drive_seq_inputs(line);
		mux_rdata_valid = field(line, C_RV);
		mux_rdata       = field(line, C_RD);
		#0.5;
		check_outputs(line);
	endtask

	initial
	begin
		wait (golden_ready);
		#(num_lines * 2 + 100);
		$display("timeout after %0d golden lines, the run did not finish", num_lines);
		$display("checks %0d errors %0d", checks, errors);
		$display("Something failed");
		$finish;
	end

	initial
	begin
		int i;
		seq_address     = '0;
		seq_bank        = '0;
		seq_cs_n        = '1;
		seq_cke         = '0;
		seq_odt         = '0;
		seq_ras_n       = '1;
		seq_cas_n       = '1;
		seq_we_n        = '1;
		seq_dqs_en      = '0;
		seq_wdata       = '0;
		seq_wdata_valid = '0;
		seq_dm          = '0;
		seq_rdata_en    = 1'b0;
		seq_read_increment_vfifo_fr = '0;
		seq_read_increment_vfifo_hr = '0;
		mux_rdata       = '0;
		mux_rdata_valid = 1'b0;
		errors = 0;
		checks = 0;
		seed   = 32'hca92;

		// unused entries stay all ones and mark the end of the file
		for (i = 0; i < COLS*MAX_LINES; i++)
			golden[i] = '1;
		$readmemh("bench/bridge_golden.txt", golden);
		num_lines = 0;
		while (num_lines < MAX_LINES && field(num_lines, C_PH) !== 32'hffffffff)
			num_lines++;
		golden_ready = 1'b1;
		if (num_lines == 0)
		begin
			$display("golden file is missing or holds no lines");
			errors++;
		end

		@(posedge reset_n_seq_clk);
		for (i = 0; i < num_lines; i++)
			run_line(i);

		errors += i_dut.i_props.failures;
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// File: bench/seq_rate_bridge_props.sv
/*
  Concurrent checks bound into seq_rate_bridge.
  Reset values are sampled on the falling edge, after the first rising edge
  in reset has cleared the registers.
*/
`timescale 1ns/1ps

module seq_rate_bridge_props (
	input logic                        seq_clk,
	input logic                        reset_n_seq_clk,
	input rate_bridge_pkg::afi_cs_t    mux_cs_n,
	input rate_bridge_pkg::afi_ctl_t   mux_ras_n,
	input rate_bridge_pkg::afi_ctl_t   mux_cas_n,
	input rate_bridge_pkg::afi_ctl_t   mux_we_n,
	input logic                        mux_rdata_en,
	input rate_bridge_pkg::afi_dqs_t   mux_wdata_valid,
	input logic                        seq_rdata_valid,
	input rate_bridge_pkg::vfifo_inc_t phy_read_increment_vfifo_fr,
	input rate_bridge_pkg::vfifo_inc_t phy_read_increment_vfifo_hr
);
	int failures = 0;

	a_reset_idle_cmd: assert property (@(negedge seq_clk)
		!reset_n_seq_clk |-> (&mux_cs_n && &mux_ras_n && &mux_cas_n && &mux_we_n))
		else
		begin
			$error("command outputs not idle during reset");
			failures++;
		end

	a_reset_no_valid: assert property (@(negedge seq_clk)
		!reset_n_seq_clk |-> (!mux_rdata_en && mux_wdata_valid == '0 && !seq_rdata_valid))
		else
		begin
			$error("rdata_en or a valid strobe active during reset");
			failures++;
		end

	// sampled values at a rising edge come from the end of the low phase
	a_vfifo_low_phase: assert property (@(posedge seq_clk) disable iff (!reset_n_seq_clk)
		phy_read_increment_vfifo_fr == '0 && phy_read_increment_vfifo_hr == '0)
		else
		begin
			$error("vfifo increment strobe seen while seq_clk was low");
			failures++;
		end

endmodule

bind seq_rate_bridge seq_rate_bridge_props i_props (.*);

// File: bench/bridge_clock_gen.sv
/*
  Clock and reset for the bridge testbench.
  Reset is released 1 ns after the last rising edge of the reset window.
*/
`timescale 1ns/1ps

module bridge_clock_gen #(
	parameter real PERIOD_NS    = 4.0,
	parameter int  RESET_CYCLES = 5
) (
	output logic seq_clk,
	output logic reset_n_seq_clk
);
	initial
	begin
		seq_clk = 1'b0;
		forever #(PERIOD_NS / 2.0) seq_clk = ~seq_clk;
	end

	initial
	begin
		reset_n_seq_clk = 1'b0;
		repeat (RESET_CYCLES) @(posedge seq_clk);
		#1 reset_n_seq_clk = 1'b1;
	end

endmodule

// File: hdl/seq_rate_bridge.sv
/*
  Rate bridge between a half-rate calibration sequencer and a full-rate PHY,
  all in the seq_clk domain. Half-rate words hold the low slot in their lower
  half. There is no back-pressure, a word is taken every cycle.
  SHIFT_ADDR_CMD = 1 delays address and command by one full-rate slot.
*/
`timescale 1ns/1ps
`include "rate_bridge_config.svh"

module seq_rate_bridge #(
	parameter int SHIFT_ADDR_CMD = 0
) (
	input  logic                        seq_clk,
	input  logic                        reset_n_seq_clk,
	input  rate_bridge_pkg::seq_addr_t  seq_address,
	input  rate_bridge_pkg::seq_bank_t  seq_bank,
	input  rate_bridge_pkg::seq_cs_t    seq_cs_n,
	input  rate_bridge_pkg::seq_cke_t   seq_cke,
	input  rate_bridge_pkg::seq_odt_t   seq_odt,
	input  rate_bridge_pkg::seq_ctl_t   seq_ras_n,
	input  rate_bridge_pkg::seq_ctl_t   seq_cas_n,
	input  rate_bridge_pkg::seq_ctl_t   seq_we_n,
	input  rate_bridge_pkg::seq_dqs_t   seq_dqs_en,
	input  rate_bridge_pkg::seq_data_t  seq_wdata,
	input  rate_bridge_pkg::seq_dqs_t   seq_wdata_valid,
	input  rate_bridge_pkg::seq_dm_t    seq_dm,
	input  logic                        seq_rdata_en,
	output rate_bridge_pkg::seq_data_t  seq_rdata,
	output logic                        seq_rdata_valid,
	input  rate_bridge_pkg::vfifo_inc_t seq_read_increment_vfifo_fr,
	input  rate_bridge_pkg::vfifo_inc_t seq_read_increment_vfifo_hr,
	output rate_bridge_pkg::afi_addr_t  mux_address,
	output rate_bridge_pkg::afi_bank_t  mux_bank,
	output rate_bridge_pkg::afi_cs_t    mux_cs_n,
	output rate_bridge_pkg::afi_cke_t   mux_cke,
	output rate_bridge_pkg::afi_odt_t   mux_odt,
	output rate_bridge_pkg::afi_ctl_t   mux_ras_n,
	output rate_bridge_pkg::afi_ctl_t   mux_cas_n,
	output rate_bridge_pkg::afi_ctl_t   mux_we_n,
	output rate_bridge_pkg::afi_dqs_t   mux_dqs_en,
	output rate_bridge_pkg::afi_data_t  mux_wdata,
	output rate_bridge_pkg::afi_dqs_t   mux_wdata_valid,
	output rate_bridge_pkg::afi_dm_t    mux_dm,
	output logic                        mux_rdata_en,
	input  rate_bridge_pkg::afi_data_t  mux_rdata,
	input  logic                        mux_rdata_valid,
	output rate_bridge_pkg::vfifo_inc_t phy_read_increment_vfifo_fr,
	output rate_bridge_pkg::vfifo_inc_t phy_read_increment_vfifo_hr
);
	cmd_pair_if   cmd_pair ();
	wdata_pair_if wdata_pair ();

	// write data is never shifted, so it is split straight into slots
	assign wdata_pair.dqs_en_l      = seq_dqs_en[0 +: `AFI_DQS_W];
	assign wdata_pair.dqs_en_h      = seq_dqs_en[`AFI_DQS_W +: `AFI_DQS_W];
	assign wdata_pair.wdata_l       = seq_wdata[0 +: `AFI_DATA_W];
	assign wdata_pair.wdata_h       = seq_wdata[`AFI_DATA_W +: `AFI_DATA_W];
	assign wdata_pair.wdata_valid_l = seq_wdata_valid[0 +: `AFI_DQS_W];
	assign wdata_pair.wdata_valid_h = seq_wdata_valid[`AFI_DQS_W +: `AFI_DQS_W];
	assign wdata_pair.dm_l          = seq_dm[0 +: `AFI_DM_W];
	assign wdata_pair.dm_h          = seq_dm[`AFI_DM_W +: `AFI_DM_W];

	cmd_slot_shifter #(
		.SHIFT_ADDR_CMD (SHIFT_ADDR_CMD)
	) i_cmd_slot_shifter (
		.*,
		.pair (cmd_pair)
	);

	ddr_phase_serializer i_ddr_phase_serializer (
		.*,
		.cmd         (cmd_pair),
		.wr          (wdata_pair),
		.vfifo_fr_in (seq_read_increment_vfifo_fr),
		.vfifo_hr_in (seq_read_increment_vfifo_hr)
	);

	read_phase_aligner i_read_phase_aligner (
		.*
	);

endmodule

// File: hdl/read_phase_aligner.sv
/*
  Pairs full-rate read beats into half-rate words. Beats are sampled on both
  edges of seq_clk, and the pairing follows the edge on which a burst starts.
  Bursts must have an even number of beats. The later beat of a pair lands in
  the upper half of seq_rdata, and the word is valid at the first rising edge
  after its second beat, 1 or 1.5 cycles after the first beat.
*/
`timescale 1ns/1ps

module read_phase_aligner (
	input  logic                       seq_clk,
	input  logic                       reset_n_seq_clk,
	input  rate_bridge_pkg::afi_data_t mux_rdata,
	input  logic                       mux_rdata_valid,
	output rate_bridge_pkg::seq_data_t seq_rdata,
	output logic                       seq_rdata_valid
);
	import rate_bridge_pkg::*;

	// beat order seen at a rising edge is fall_prev, then rise, then fall
	afi_data_t fall_data;
	afi_data_t rise_data;
	afi_data_t fall_prev_data;
	logic      fall_valid;
	logic      rise_valid;
	logic      fall_prev_valid;
	logic      rise_phase_q;
	logic      start_rise;
	logic      start_fall;
	logic      rise_phase;
	logic      rise_pair;
	logic      fall_pair;

	always_ff @(negedge seq_clk or negedge reset_n_seq_clk)
	begin
		if (!reset_n_seq_clk)
			fall_valid <= 1'b0;
		else
			fall_valid <= mux_rdata_valid;
	end

	always_ff @(negedge seq_clk)
	begin
		fall_data <= mux_rdata;
	end

	assign start_rise = rise_valid & ~fall_prev_valid;
	assign start_fall = fall_valid & ~rise_valid;
	// a burst start decides the phase at once, otherwise the last phase holds
	assign rise_phase = start_rise | (~start_fall & rise_phase_q);
	assign rise_pair  = rise_phase & rise_valid & fall_valid;
	assign fall_pair  = ~rise_phase & fall_prev_valid & rise_valid;

	always_ff @(posedge seq_clk or negedge reset_n_seq_clk)
	begin
		if (!reset_n_seq_clk)
		begin
			rise_valid      <= 1'b0;
			fall_prev_valid <= 1'b0;
			rise_phase_q    <= 1'b0;
			seq_rdata_valid <= 1'b0;
		end
		else
		begin
			rise_valid      <= mux_rdata_valid;
			fall_prev_valid <= fall_valid;
			rise_phase_q    <= rise_phase;
			seq_rdata_valid <= rise_pair | fall_pair;
		end
	end

	always_ff @(posedge seq_clk)
	begin
		rise_data      <= mux_rdata;
		fall_prev_data <= fall_data;
		if (rise_pair)
			seq_rdata <= {fall_data, rise_data};
		else if (fall_pair)
			seq_rdata <= {rise_data, fall_prev_data};
	end

endmodule

// File: hdl/ddr_phase_serializer.sv
/*
  Registers command and write-data slot pairs and puts them on the full-rate
  outputs by clock phase. The low slot is driven while seq_clk is high and the
  high slot while it is low, so the outputs change on both edges.
  A pair sampled at rising edge N is launched at edge N+1.
  The vfifo strobes are not registered and only pass while seq_clk is high.
*/
`timescale 1ns/1ps
`include "rate_bridge_config.svh"

module ddr_phase_serializer (
	input  logic                        seq_clk,
	input  logic                        reset_n_seq_clk,
	cmd_pair_if.consumer                cmd,
	wdata_pair_if.consumer              wr,
	input  rate_bridge_pkg::vfifo_inc_t vfifo_fr_in,
	input  rate_bridge_pkg::vfifo_inc_t vfifo_hr_in,
	output rate_bridge_pkg::afi_addr_t  mux_address,
	output rate_bridge_pkg::afi_bank_t  mux_bank,
	output rate_bridge_pkg::afi_cs_t    mux_cs_n,
	output rate_bridge_pkg::afi_cke_t   mux_cke,
	output rate_bridge_pkg::afi_odt_t   mux_odt,
	output rate_bridge_pkg::afi_ctl_t   mux_ras_n,
	output rate_bridge_pkg::afi_ctl_t   mux_cas_n,
	output rate_bridge_pkg::afi_ctl_t   mux_we_n,
	output logic                        mux_rdata_en,
	output rate_bridge_pkg::afi_dqs_t   mux_dqs_en,
	output rate_bridge_pkg::afi_data_t  mux_wdata,
	output rate_bridge_pkg::afi_dqs_t   mux_wdata_valid,
	output rate_bridge_pkg::afi_dm_t    mux_dm,
	output rate_bridge_pkg::vfifo_inc_t phy_read_increment_vfifo_fr,
	output rate_bridge_pkg::vfifo_inc_t phy_read_increment_vfifo_hr
);
	// one slot is every full-rate field packed in output port order
	localparam int SLOT_W = `AFI_ADDR_W + `AFI_BANK_W + `AFI_CS_W + `AFI_CKE_W + `AFI_ODT_W
	                      + 3*`AFI_CTL_W + 1 + 2*`AFI_DQS_W + `AFI_DATA_W + `AFI_DM_W;

	localparam logic [SLOT_W-1:0] SLOT_IDLE = {
		{`AFI_ADDR_W{1'b0}}, {`AFI_BANK_W{1'b0}}, {`AFI_CS_W{1'b1}},
		{`AFI_CKE_W{1'b0}}, {`AFI_ODT_W{1'b0}}, {3*`AFI_CTL_W{1'b1}}, 1'b0,
		{`AFI_DQS_W{1'b0}}, {`AFI_DATA_W{1'b0}}, {`AFI_DQS_W{1'b0}}, {`AFI_DM_W{1'b0}}
	};

	logic [SLOT_W-1:0] slot_l_d;
	logic [SLOT_W-1:0] slot_h_d;
	logic [SLOT_W-1:0] cap_l_q;
	logic [SLOT_W-1:0] cap_h_q;
	logic [SLOT_W-1:0] out_l_q;
	logic [SLOT_W-1:0] out_h_q;

	assign slot_l_d = {cmd.address_l, cmd.bank_l, cmd.cs_n_l, cmd.cke_l, cmd.odt_l,
	                   cmd.ras_n_l, cmd.cas_n_l, cmd.we_n_l, cmd.rdata_en_l,
	                   wr.dqs_en_l, wr.wdata_l, wr.wdata_valid_l, wr.dm_l};
	assign slot_h_d = {cmd.address_h, cmd.bank_h, cmd.cs_n_h, cmd.cke_h, cmd.odt_h,
	                   cmd.ras_n_h, cmd.cas_n_h, cmd.we_n_h, cmd.rdata_en_h,
	                   wr.dqs_en_h, wr.wdata_h, wr.wdata_valid_h, wr.dm_h};

	// capture stage followed by launch stage
	always_ff @(posedge seq_clk or negedge reset_n_seq_clk)
	begin
		if (!reset_n_seq_clk)
		begin
			cap_l_q <= SLOT_IDLE;
			cap_h_q <= SLOT_IDLE;
			out_l_q <= SLOT_IDLE;
			out_h_q <= SLOT_IDLE;
		end
		else
		begin
			cap_l_q <= slot_l_d;
			cap_h_q <= slot_h_d;
			out_l_q <= cap_l_q;
			out_h_q <= cap_h_q;
		end
	end

	assign {mux_address, mux_bank, mux_cs_n, mux_cke, mux_odt, mux_ras_n, mux_cas_n,
	        mux_we_n, mux_rdata_en, mux_dqs_en, mux_wdata, mux_wdata_valid, mux_dm}
	       = seq_clk ? out_l_q : out_h_q;

	assign phy_read_increment_vfifo_fr = seq_clk ? vfifo_fr_in : '0;
	assign phy_read_increment_vfifo_hr = seq_clk ? vfifo_hr_in : '0;

endmodule

// File: hdl/cmd_slot_shifter.sv
/*
  Splits half-rate commands into low/high slot pairs.
  SHIFT_ADDR_CMD = 1 delays the command stream by one full-rate slot. The first
  low slot after reset is then an idle command (cs_n, ras_n, cas_n, we_n high).
  rdata_en has one bit per half-rate word and is copied into both slots.
*/
`timescale 1ns/1ps
`include "rate_bridge_config.svh"

module cmd_slot_shifter #(
	parameter int SHIFT_ADDR_CMD = 0
) (
	input  logic                       seq_clk,
	input  logic                       reset_n_seq_clk,
	input  rate_bridge_pkg::seq_addr_t seq_address,
	input  rate_bridge_pkg::seq_bank_t seq_bank,
	input  rate_bridge_pkg::seq_cs_t   seq_cs_n,
	input  rate_bridge_pkg::seq_cke_t  seq_cke,
	input  rate_bridge_pkg::seq_odt_t  seq_odt,
	input  rate_bridge_pkg::seq_ctl_t  seq_ras_n,
	input  rate_bridge_pkg::seq_ctl_t  seq_cas_n,
	input  rate_bridge_pkg::seq_ctl_t  seq_we_n,
	input  logic                       seq_rdata_en,
	cmd_pair_if.producer               pair
);
	import rate_bridge_pkg::*;

	localparam bit SHIFT = (SHIFT_ADDR_CMD != 0);

	// high slot of the previous word
	afi_addr_t address_h_q;
	afi_bank_t bank_h_q;
	afi_cs_t   cs_n_h_q;
	afi_cke_t  cke_h_q;
	afi_odt_t  odt_h_q;
	afi_ctl_t  ras_n_h_q;
	afi_ctl_t  cas_n_h_q;
	afi_ctl_t  we_n_h_q;
	logic      rdata_en_h_q;

	always_ff @(posedge seq_clk or negedge reset_n_seq_clk)
	begin
		if (!reset_n_seq_clk)
		begin
			address_h_q  <= '0;
			bank_h_q     <= '0;
			cs_n_h_q     <= '1;
			cke_h_q      <= '0;
			odt_h_q      <= '0;
			ras_n_h_q    <= '1;
			cas_n_h_q    <= '1;
			we_n_h_q     <= '1;
			rdata_en_h_q <= 1'b0;
		end
		else
		begin
			address_h_q  <= seq_address[`AFI_ADDR_W +: `AFI_ADDR_W];
			bank_h_q     <= seq_bank[`AFI_BANK_W +: `AFI_BANK_W];
			cs_n_h_q     <= seq_cs_n[`AFI_CS_W +: `AFI_CS_W];
			cke_h_q      <= seq_cke[`AFI_CKE_W +: `AFI_CKE_W];
			odt_h_q      <= seq_odt[`AFI_ODT_W +: `AFI_ODT_W];
			ras_n_h_q    <= seq_ras_n[`AFI_CTL_W +: `AFI_CTL_W];
			cas_n_h_q    <= seq_cas_n[`AFI_CTL_W +: `AFI_CTL_W];
			we_n_h_q     <= seq_we_n[`AFI_CTL_W +: `AFI_CTL_W];
			rdata_en_h_q <= seq_rdata_en;
		end
	end

	// in shift mode the low slot takes the previous high half and the high slot
	// takes the current low half
	assign pair.address_l  = SHIFT ? address_h_q : seq_address[0 +: `AFI_ADDR_W];
	assign pair.address_h  = SHIFT ? seq_address[0 +: `AFI_ADDR_W]
	                               : seq_address[`AFI_ADDR_W +: `AFI_ADDR_W];
	assign pair.bank_l     = SHIFT ? bank_h_q : seq_bank[0 +: `AFI_BANK_W];
	assign pair.bank_h     = SHIFT ? seq_bank[0 +: `AFI_BANK_W]
	                               : seq_bank[`AFI_BANK_W +: `AFI_BANK_W];
	assign pair.cs_n_l     = SHIFT ? cs_n_h_q : seq_cs_n[0 +: `AFI_CS_W];
	assign pair.cs_n_h     = SHIFT ? seq_cs_n[0 +: `AFI_CS_W] : seq_cs_n[`AFI_CS_W +: `AFI_CS_W];
	assign pair.cke_l      = SHIFT ? cke_h_q : seq_cke[0 +: `AFI_CKE_W];
	assign pair.cke_h      = SHIFT ? seq_cke[0 +: `AFI_CKE_W] : seq_cke[`AFI_CKE_W +: `AFI_CKE_W];
	assign pair.odt_l      = SHIFT ? odt_h_q : seq_odt[0 +: `AFI_ODT_W];
	assign pair.odt_h      = SHIFT ? seq_odt[0 +: `AFI_ODT_W] : seq_odt[`AFI_ODT_W +: `AFI_ODT_W];
	assign pair.ras_n_l    = SHIFT ? ras_n_h_q : seq_ras_n[0 +: `AFI_CTL_W];
	assign pair.ras_n_h    = SHIFT ? seq_ras_n[0 +: `AFI_CTL_W]
	                               : seq_ras_n[`AFI_CTL_W +: `AFI_CTL_W];
	assign pair.cas_n_l    = SHIFT ? cas_n_h_q : seq_cas_n[0 +: `AFI_CTL_W];
	assign pair.cas_n_h    = SHIFT ? seq_cas_n[0 +: `AFI_CTL_W]
	                               : seq_cas_n[`AFI_CTL_W +: `AFI_CTL_W];
	assign pair.we_n_l     = SHIFT ? we_n_h_q : seq_we_n[0 +: `AFI_CTL_W];
	assign pair.we_n_h     = SHIFT ? seq_we_n[0 +: `AFI_CTL_W] : seq_we_n[`AFI_CTL_W +: `AFI_CTL_W];
	assign pair.rdata_en_l = SHIFT ? rdata_en_h_q : seq_rdata_en;
	assign pair.rdata_en_h = seq_rdata_en;

endmodule

// File: hdl/rate_bridge_if.sv
/*
  Slot pairs between the half-rate split and the phase serializer.
  The _l field goes out while seq_clk is high, the _h field while it is low.
  Plain levels sampled every cycle, there is no handshake.
*/
`timescale 1ns/1ps

interface cmd_pair_if;
	import rate_bridge_pkg::*;

	afi_addr_t address_l, address_h;
	afi_bank_t bank_l, bank_h;
	afi_cs_t   cs_n_l, cs_n_h;
	afi_cke_t  cke_l, cke_h;
	afi_odt_t  odt_l, odt_h;
	afi_ctl_t  ras_n_l, ras_n_h;
	afi_ctl_t  cas_n_l, cas_n_h;
	afi_ctl_t  we_n_l, we_n_h;
	logic      rdata_en_l, rdata_en_h;

	modport producer (
		output address_l, address_h, bank_l, bank_h, cs_n_l, cs_n_h,
		output cke_l, cke_h, odt_l, odt_h, ras_n_l, ras_n_h,
		output cas_n_l, cas_n_h, we_n_l, we_n_h, rdata_en_l, rdata_en_h
	);
	modport consumer (
		input address_l, address_h, bank_l, bank_h, cs_n_l, cs_n_h,
		input cke_l, cke_h, odt_l, odt_h, ras_n_l, ras_n_h,
		input cas_n_l, cas_n_h, we_n_l, we_n_h, rdata_en_l, rdata_en_h
	);
endinterface

interface wdata_pair_if;
	import rate_bridge_pkg::*;

	afi_dqs_t  dqs_en_l, dqs_en_h;
	afi_data_t wdata_l, wdata_h;
	afi_dqs_t  wdata_valid_l, wdata_valid_h;
	afi_dm_t   dm_l, dm_h;

	modport producer (
		output dqs_en_l, dqs_en_h, wdata_l, wdata_h,
		output wdata_valid_l, wdata_valid_h, dm_l, dm_h
	);
	modport consumer (
		input dqs_en_l, dqs_en_h, wdata_l, wdata_h,
		input wdata_valid_l, wdata_valid_h, dm_l, dm_h
	);
endinterface

// File: hdl/rate_bridge_pkg.sv
/*
  Vector types for the full-rate (afi_*) and half-rate (seq_*) fields.
  Widths come from rate_bridge_config.svh.
*/
`include "rate_bridge_config.svh"

package rate_bridge_pkg;

	typedef logic [`AFI_ADDR_W-1:0]   afi_addr_t;
	typedef logic [`AFI_BANK_W-1:0]   afi_bank_t;
	typedef logic [`AFI_CS_W-1:0]     afi_cs_t;
	typedef logic [`AFI_CKE_W-1:0]    afi_cke_t;
	typedef logic [`AFI_ODT_W-1:0]    afi_odt_t;
	typedef logic [`AFI_CTL_W-1:0]    afi_ctl_t;
	typedef logic [`AFI_DATA_W-1:0]   afi_data_t;
	typedef logic [`AFI_DQS_W-1:0]    afi_dqs_t;
	typedef logic [`AFI_DM_W-1:0]     afi_dm_t;
	typedef logic [`READ_DQS_W-1:0]   vfifo_inc_t;

	typedef logic [2*`AFI_DATA_W-1:0] seq_data_t;
	typedef logic [2*`AFI_ADDR_W-1:0] seq_addr_t;
	typedef logic [2*`AFI_BANK_W-1:0] seq_bank_t;
	typedef logic [2*`AFI_CS_W-1:0]   seq_cs_t;
	typedef logic [2*`AFI_CKE_W-1:0]  seq_cke_t;
	typedef logic [2*`AFI_ODT_W-1:0]  seq_odt_t;
	typedef logic [2*`AFI_CTL_W-1:0]  seq_ctl_t;
	typedef logic [2*`AFI_DQS_W-1:0]  seq_dqs_t;
	typedef logic [2*`AFI_DM_W-1:0]   seq_dm_t;

endpackage

// File: hdl/rate_bridge_config.svh
/*
  Full-rate widths of the bridge. Every half-rate field is twice as wide,
  with the low slot in the lower half of the word.
  READ_DQS_W sets the width of both vfifo increment strobes.
*/
`ifndef RATE_BRIDGE_CONFIG_SVH
`define RATE_BRIDGE_CONFIG_SVH

`define AFI_ADDR_W 13
`define AFI_BANK_W 3
`define AFI_CS_W   1
`define AFI_CKE_W  1
`define AFI_ODT_W  1
`define AFI_CTL_W  1
`define AFI_DATA_W 16
`define AFI_DQS_W  2
`define AFI_DM_W   2
`define READ_DQS_W 2

`endif
